/* src.f */
+incdir+include
rtl/tcu_fmt_pkg.sv
rtl/tcu_apb_pkg.sv
rtl/tcu_issue_if.sv
rtl/tcu_prep_if.sv
rtl/tcu_operand_prep.sv
rtl/tcu_slice_mul.sv
rtl/tcu_dot_reduce.sv
rtl/tcu_apb_regs.sv
rtl/tcu_dot_top.sv
bench/tcu_dot_properties.sv
bench/tcu_dot_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tcu_dot_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tcu_dot_tb.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

module tcu_dot_tb;

    localparam int CLK_PERIOD = 10;
    localparam int N_OPS      = 200;
    localparam int N_B2B      = 12;
    localparam int N_STALL    = 10;
    localparam int N_REJ      = 8;
    localparam int OP_XFERS   = 8;
    // APB transfers over the whole run
    localparam int N_XFERS = 8 + (2 * N_OPS + N_STALL) * OP_XFERS + 2 * N_B2B + 3
                             + 2 * N_REJ + 2 + 8;

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`TCU_ADDR_W-1:0] paddr;
    logic [`TCU_DATA_W-1:0] pwdata;
    logic [`TCU_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;

    // Expected register contents by word address
    logic [`TCU_DATA_W-1:0] exp_reg [8];

    tcu_dot_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(input string name, input logic [`TCU_DATA_W-1:0] got,
                              input logic [`TCU_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_fmt(input string name, input tcu_fmt_pkg::tcu_fmt_e got,
                             input tcu_fmt_pkg::tcu_fmt_e exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // Called 1 ns after a rising edge and returns 1 ns after the completing edge
    task automatic apb_xfer(input logic write, input logic [`TCU_ADDR_W-1:0] addr,
                            input logic [`TCU_DATA_W-1:0] wdata,
                            output logic [`TCU_DATA_W-1:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [`TCU_ADDR_W-1:0] addr,
                             input logic [`TCU_DATA_W-1:0] data, output logic err);
        logic [`TCU_DATA_W-1:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [`TCU_ADDR_W-1:0] addr,
                            output logic [`TCU_DATA_W-1:0] data, output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic read_reg(input logic [`TCU_ADDR_W-1:0] addr,
                            output logic [`TCU_DATA_W-1:0] data);
        logic err;
        apb_read(addr, data, err);
        check_err("pslverr", err, 1'b0);
    endtask

    task automatic write_reg(input int idx, input logic [`TCU_DATA_W-1:0] data);
        logic err;
        apb_write(`TCU_ADDR_W'(4 * idx), data, err);
        check_err("pslverr", err, 1'b0);
        exp_reg[idx] = data;
    endtask

    // Sum of element products plus C modulo 2^32
    task automatic dot_model(input tcu_fmt_pkg::tcu_fmt_e fmt,
                             input logic [`TCU_N_WORDS-1:0][`TCU_DATA_W-1:0] a,
                             input logic [`TCU_N_WORDS-1:0][`TCU_DATA_W-1:0] b,
                             input logic [`TCU_DATA_W-1:0] c,
                             output logic [`TCU_DATA_W-1:0] res);
        int                 ew;
        logic signed [31:0] ea;
        logic signed [31:0] eb;
        logic [31:0]        acc;
        ew  = (fmt == tcu_fmt_pkg::FMT_I4 || fmt == tcu_fmt_pkg::FMT_U4) ? 4 : 8;
        acc = c;
        for (int w = 0; w < `TCU_N_WORDS; w++) begin
            for (int i = 0; i < `TCU_DATA_W / ew; i++) begin
                ea = (a[w] >> (i * ew)) & ((1 << ew) - 1);
                eb = (b[w] >> (i * ew)) & ((1 << ew) - 1);
                if (fmt == tcu_fmt_pkg::FMT_I8 || fmt == tcu_fmt_pkg::FMT_I4) begin
                    if (ea >= (1 << (ew - 1))) ea = ea - (1 << ew);
                    if (eb >= (1 << (ew - 1))) eb = eb - (1 << ew);
                end
                acc = acc + ea * eb;
            end
        end
        res = acc;
    endtask

    function automatic logic [`TCU_DATA_W-1:0] rand_word();
        // Extreme element values now and then
        case ($urandom_range(0, 7))
            0: return 32'h8080_8080;
            1: return 32'hFFFF_FFFF;
            2: return 32'h7F7F_7F7F;
            3: return 32'h8888_8888;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [`TCU_ADDR_W-1:0] unmapped_addr();
        logic [`TCU_ADDR_W-1:0] addr;
        addr = `TCU_ADDR_W'($urandom);
        while (addr < 8'h20 && addr[1:0] == 2'b00) begin
            addr = `TCU_ADDR_W'($urandom);
        end
        return addr;
    endfunction

    task automatic start_op(input tcu_fmt_pkg::tcu_fmt_e fmt);
        logic                   err;
        logic [`TCU_DATA_W-1:0] res;
        apb_write(tcu_apb_pkg::REG_CTRL, {23'd0, 1'b1, 6'd0, fmt}, err);
        check_err("pslverr", err, 1'b0);
        exp_reg[0] = {30'd0, fmt};
        dot_model(fmt, {exp_reg[2], exp_reg[1]}, {exp_reg[4], exp_reg[3]}, exp_reg[5], res);
        exp_reg[6] = res;
        exp_reg[7] = {24'd0, exp_reg[7][7:0] + 8'd1};
    endtask

    // New operands, start, then a RESULT read straight away
    task automatic run_op(input tcu_fmt_pkg::tcu_fmt_e fmt);
        logic [`TCU_DATA_W-1:0] d;
        for (int i = 1; i <= 5; i++) begin
            write_reg(i, rand_word());
        end
        start_op(fmt);
        read_reg(tcu_apb_pkg::REG_RESULT, d);
        check_word("RESULT", d, exp_reg[6]);
        read_reg(tcu_apb_pkg::REG_CTRL, d);
        check_fmt("CTRL.fmt", tcu_fmt_pkg::tcu_fmt_e'(d[1:0]), fmt);
    endtask

    task automatic check_all_regs();
        logic [`TCU_DATA_W-1:0] d;
        tcu_apb_pkg::tcu_reg_e  r;
        for (int i = 0; i < 8; i++) begin
            r = tcu_apb_pkg::tcu_reg_e'(`TCU_ADDR_W'(4 * i));
            read_reg(r, d);
            if (i == 0) begin
                check_fmt("CTRL.fmt", tcu_fmt_pkg::tcu_fmt_e'(d[1:0]),
                          tcu_fmt_pkg::tcu_fmt_e'(exp_reg[0][1:0]));
            end
            check_word(r.name(), d, exp_reg[i]);
        end
    endtask

    initial begin : watchdog
        #((N_XFERS * 40 + 1000) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", N_XFERS * 40 + 1000);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [`TCU_DATA_W-1:0] d;
        logic                   err;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(80229));
        foreach (exp_reg[i]) exp_reg[i] = '0;
        exp_reg[0] = {30'd0, tcu_fmt_pkg::FMT_I8};
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        check_all_regs();

        for (int k = 0; k < N_OPS; k++) begin
            run_op(tcu_fmt_pkg::tcu_fmt_e'(2'($urandom_range(0, 1))));
        end
        for (int k = 0; k < N_OPS; k++) begin
            run_op(tcu_fmt_pkg::tcu_fmt_e'(2'($urandom_range(2, 3))));
        end

        // Starts with one fresh operand word between them so only the last two overlap
        for (int k = 0; k < N_B2B; k++) begin
            write_reg(1 + k % 5, rand_word());
            start_op(tcu_fmt_pkg::tcu_fmt_e'(2'($urandom_range(0, 3))));
        end
        start_op(tcu_fmt_pkg::tcu_fmt_e'(2'($urandom_range(0, 3))));
        read_reg(tcu_apb_pkg::REG_RESULT, d);
        check_word("RESULT", d, exp_reg[6]);
        read_reg(tcu_apb_pkg::REG_STATUS, d);
        check_word("STATUS", d, exp_reg[7]);

        for (int k = 0; k < N_STALL; k++) begin
            run_op(tcu_fmt_pkg::tcu_fmt_e'(2'(k % 4)));
        end

        for (int k = 0; k < N_REJ; k++) begin
            apb_read(unmapped_addr(), d, err);
            check_err("pslverr", err, 1'b1);
            apb_write(unmapped_addr(), rand_word(), err);
            check_err("pslverr", err, 1'b1);
        end
        apb_write(tcu_apb_pkg::REG_RESULT, rand_word(), err);
        check_err("pslverr", err, 1'b1);
        apb_write(tcu_apb_pkg::REG_STATUS, rand_word(), err);
        check_err("pslverr", err, 1'b1);
        check_all_regs();

        $display("Regression passed");
        $finish;
    end

endmodule

/* bench/tcu_dot_properties.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

module tcu_dot_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input logic [`TCU_ADDR_W-1:0] paddr,
    input logic [`TCU_DATA_W-1:0] pwdata,
    input logic [`TCU_DATA_W-1:0] prdata,
    input logic                   pready,
    input logic                   pslverr,
    input logic                   res_valid
);

    logic start;

    // Completing CTRL write with the start bit set
    assign start = psel && penable && pready && pwrite
                   && (paddr == tcu_apb_pkg::REG_CTRL) && pwdata[8];

    a_slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable && pready))
        else $error("pslverr raised outside a completing access phase");

    a_prdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (!pready && $past(!pready)) |-> $stable(prdata))
        else $error("prdata changed while pready was low");

    a_start_latency: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid == $past(start, 3))
        else $error("res_valid does not follow a start by three cycles");

endmodule

bind tcu_dot_top tcu_dot_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .res_valid (res_valid)
);

/* rtl/tcu_dot_top.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

module tcu_dot_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`TCU_ADDR_W-1:0] paddr,
    input  logic [`TCU_DATA_W-1:0] pwdata,
    output logic [`TCU_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic                                     part_valid;
    logic [`TCU_N_SLICES-1:0][`TCU_PART_W-1:0] part;
    logic [`TCU_DATA_W-1:0]                   part_c;
    logic                                     res_valid;
    logic [`TCU_DATA_W-1:0]                   res;

    tcu_issue_if issue_if ();
    tcu_prep_if  prep_if ();

    tcu_apb_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .issue     (issue_if.src),
        .res_valid (res_valid),
        .res       (res)
    );

    tcu_operand_prep u_prep (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue_if.dst),
        .prep  (prep_if.src)
    );

    tcu_slice_mul u_mul (
        .clk        (clk),
        .rst_n      (rst_n),
        .prep       (prep_if.dst),
        .part_valid (part_valid),
        .part       (part),
        .part_c     (part_c)
    );

    tcu_dot_reduce u_reduce (
        .clk        (clk),
        .rst_n      (rst_n),
        .part_valid (part_valid),
        .part       (part),
        .part_c     (part_c),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

/* rtl/tcu_apb_regs.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

module tcu_apb_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`TCU_ADDR_W-1:0] paddr,
    input  logic [`TCU_DATA_W-1:0] pwdata,
    output logic [`TCU_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    tcu_issue_if.src               issue,
    input  logic                   res_valid,
    input  logic [`TCU_DATA_W-1:0] res
);

    tcu_apb_pkg::tcu_apb_state_e              state_q, state_d;
    tcu_apb_pkg::tcu_reg_e                    reg_addr;
    tcu_fmt_pkg::tcu_fmt_e                    fmt_q;
    logic [`TCU_N_WORDS-1:0][`TCU_DATA_W-1:0] a_q, b_q;
    logic [`TCU_DATA_W-1:0]                   c_q, result_q, rdata;
    logic [7:0]                               done_q;
    logic [1:0]                               inflight_q;
    logic                                     busy, rd_result, addr_err, xfer, wr_ok, start;

    assign reg_addr  = tcu_apb_pkg::tcu_reg_e'(paddr);
    assign busy      = (inflight_q != 2'd0);
    assign rd_result = !pwrite && (reg_addr == tcu_apb_pkg::REG_RESULT);

    always_comb begin
        rdata    = '0;
        addr_err = 1'b0;
        case (reg_addr)
            tcu_apb_pkg::REG_CTRL:   rdata = {30'd0, fmt_q};
            tcu_apb_pkg::REG_A0:     rdata = a_q[0];
            tcu_apb_pkg::REG_A1:     rdata = a_q[1];
            tcu_apb_pkg::REG_B0:     rdata = b_q[0];
            tcu_apb_pkg::REG_B1:     rdata = b_q[1];
            tcu_apb_pkg::REG_C:      rdata = c_q;
            tcu_apb_pkg::REG_RESULT: begin
                rdata    = result_q;
                addr_err = pwrite;
            end
            tcu_apb_pkg::REG_STATUS: begin
                rdata    = {23'd0, busy, done_q};
                addr_err = pwrite;
            end
            default:                 addr_err = 1'b1;
        endcase
    end

    // RESULT reads wait until every operation in flight has retired
    always_comb begin
        case (state_q)
            tcu_apb_pkg::ST_ACCESS: pready = !(rd_result && busy);
            tcu_apb_pkg::ST_DRAIN:  pready = !busy;
            default:                pready = 1'b0;
        endcase
    end

    assign xfer    = psel && penable && pready;
    assign wr_ok   = xfer && pwrite && !addr_err;
    assign pslverr = xfer && addr_err;
    assign prdata  = (xfer && !pwrite) ? rdata : '0;
    assign start   = wr_ok && (reg_addr == tcu_apb_pkg::REG_CTRL) && pwdata[8];

    always_comb begin
        state_d = state_q;
        case (state_q)
            tcu_apb_pkg::ST_IDLE: begin
                if (psel && !penable) state_d = tcu_apb_pkg::ST_ACCESS;
            end
            tcu_apb_pkg::ST_ACCESS: begin
                if (!psel) state_d = tcu_apb_pkg::ST_IDLE;
                else if (penable) state_d = pready ? tcu_apb_pkg::ST_IDLE : tcu_apb_pkg::ST_DRAIN;
            end
            tcu_apb_pkg::ST_DRAIN: begin
                if (!psel || pready) state_d = tcu_apb_pkg::ST_IDLE;
            end
            default: state_d = tcu_apb_pkg::ST_IDLE;
        endcase
    end

    // Operand words are already stored when the start write lands
    assign issue.valid = start;
    assign issue.fmt   = tcu_fmt_pkg::tcu_fmt_e'(pwdata[1:0]);
    assign issue.a     = a_q;
    assign issue.b     = b_q;
    assign issue.c     = c_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= tcu_apb_pkg::ST_IDLE;
            fmt_q      <= tcu_fmt_pkg::FMT_I8;
            a_q        <= '0;
            b_q        <= '0;
            c_q        <= '0;
            result_q   <= '0;
            done_q     <= '0;
            inflight_q <= '0;
        end else begin
            state_q    <= state_d;
            inflight_q <= inflight_q + 2'(start) - 2'(res_valid);
            if (res_valid) begin
                result_q <= res;
                done_q   <= done_q + 8'd1;
            end
            if (wr_ok) begin
                case (reg_addr)
                    tcu_apb_pkg::REG_CTRL: fmt_q  <= tcu_fmt_pkg::tcu_fmt_e'(pwdata[1:0]);
                    tcu_apb_pkg::REG_A0:   a_q[0] <= pwdata;
                    tcu_apb_pkg::REG_A1:   a_q[1] <= pwdata;
                    tcu_apb_pkg::REG_B0:   b_q[0] <= pwdata;
                    tcu_apb_pkg::REG_B1:   b_q[1] <= pwdata;
                    tcu_apb_pkg::REG_C:    c_q    <= pwdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* rtl/tcu_dot_reduce.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

module tcu_dot_reduce (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     part_valid,
    input  logic [`TCU_N_SLICES-1:0][`TCU_PART_W-1:0] part,
    input  logic [`TCU_DATA_W-1:0]                   part_c,
    output logic                                     res_valid,
    output logic [`TCU_DATA_W-1:0]                   res
);

    logic [`TCU_DATA_W-1:0] sum_d;

    // Wraps modulo 2^32
    always_comb begin
        sum_d = part_c;
        for (int s = 0; s < `TCU_N_SLICES; s++) begin
            sum_d = sum_d + `TCU_DATA_W'($signed(part[s]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= part_valid;
        end
    end

    always_ff @(posedge clk) begin
        res <= sum_d;
    end

endmodule

/* rtl/tcu_slice_mul.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

module tcu_slice_mul (
    input  logic                                     clk,
    input  logic                                     rst_n,
    tcu_prep_if.dst                                  prep,
    output logic                                     part_valid,
    output logic [`TCU_N_SLICES-1:0][`TCU_PART_W-1:0] part,
    output logic [`TCU_DATA_W-1:0]                   part_c
);

    logic [`TCU_N_SLICES-1:0][`TCU_PART_W-1:0] part_d;
    logic                                     is_signed;

    assign is_signed = tcu_fmt_pkg::fmt_signed(prep.fmt);

    for (genvar s = 0; s < `TCU_N_SLICES; s++) begin : g_slice
        logic [1:0][15:0]        p8;
        logic [1:0][16:0]        sp8;
        logic [3:0][7:0]         p4;
        logic [3:0][9:0]         sp4;
        logic [16:0]             sum8;
        logic [9:0]              sum4;
        logic [`TCU_PART_W-1:0]  merged;

        // Two byte products per slice
        for (genvar j = 0; j < 2; j++) begin : g_i8
            logic [15:0] sgn8;
            assign p8[j]  = prep.mag_a[s*4+j] * prep.mag_b[s*4+j];
            assign sgn8   = prep.neg[s*4+j] ? -p8[j] : p8[j];
            assign sp8[j] = is_signed ? {sgn8[15], sgn8} : {1'b0, p8[j]};
        end

        // Four nibble products per slice
        for (genvar j = 0; j < 4; j++) begin : g_i4
            logic [7:0] sgn4;
            assign p4[j]  = prep.mag_a[s*4+j][3:0] * prep.mag_b[s*4+j][3:0];
            assign sgn4   = prep.neg[s*4+j] ? -p4[j] : p4[j];
            assign sp4[j] = is_signed ? {{2{sgn4[7]}}, sgn4} : {2'd0, p4[j]};
        end

        assign sum8 = sp8[0] + sp8[1];
        assign sum4 = sp4[0] + sp4[1] + sp4[2] + sp4[3];

        always_comb begin
            case (prep.fmt)
                tcu_fmt_pkg::FMT_I8: merged = `TCU_PART_W'($signed(sum8));
                tcu_fmt_pkg::FMT_U8: merged = `TCU_PART_W'(sum8);
                tcu_fmt_pkg::FMT_I4: merged = `TCU_PART_W'($signed(sum4));
                default:             merged = `TCU_PART_W'(sum4);
            endcase
        end

        assign part_d[s] = merged;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            part_valid <= 1'b0;
        end else begin
            part_valid <= prep.valid;
        end
    end

    always_ff @(posedge clk) begin
        part   <= part_d;
        part_c <= prep.c;
    end

endmodule

/* rtl/tcu_operand_prep.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

module tcu_operand_prep (
    input  logic     clk,
    input  logic     rst_n,
    tcu_issue_if.dst issue,
    tcu_prep_if.src  prep
);

    localparam int N_SLOTS = 4 * `TCU_N_SLICES;
    localparam int BW      = tcu_fmt_pkg::BYTE_W;
    localparam int NW      = tcu_fmt_pkg::NIBBLE_W;

    logic [N_SLOTS-1:0][7:0] mag_a_d;
    logic [N_SLOTS-1:0][7:0] mag_b_d;
    logic [N_SLOTS-1:0]      neg_d;
    logic                    is_signed;
    logic                    is_nibble;

    assign is_signed = tcu_fmt_pkg::fmt_signed(issue.fmt);
    assign is_nibble = tcu_fmt_pkg::fmt_nibble(issue.fmt);

    for (genvar s = 0; s < `TCU_N_SLICES; s++) begin : g_slice
        for (genvar j = 0; j < 4; j++) begin : g_slot
            // Byte lanes repeat in slots 2 and 3 and are masked off below
            localparam int BOFF = (s % 2) * 16 + (j % 2) * BW;
            localparam int NOFF = (s % 2) * 16 + j * NW;
            logic [BW-1:0] ea8, eb8, abs_a8, abs_b8;
            logic [NW-1:0] ea4, eb4, abs_a4, abs_b4;

            assign ea8 = issue.a[s / 2][BOFF +: BW];
            assign eb8 = issue.b[s / 2][BOFF +: BW];
            assign ea4 = issue.a[s / 2][NOFF +: NW];
            assign eb4 = issue.b[s / 2][NOFF +: NW];

            assign abs_a8 = (is_signed && ea8[BW-1]) ? -ea8 : ea8;
            assign abs_b8 = (is_signed && eb8[BW-1]) ? -eb8 : eb8;
            assign abs_a4 = (is_signed && ea4[NW-1]) ? -ea4 : ea4;
            assign abs_b4 = (is_signed && eb4[NW-1]) ? -eb4 : eb4;

            assign mag_a_d[s*4+j] = is_nibble ? {4'd0, abs_a4} : (j < 2) ? abs_a8 : 8'd0;
            assign mag_b_d[s*4+j] = is_nibble ? {4'd0, abs_b4} : (j < 2) ? abs_b8 : 8'd0;
            assign neg_d[s*4+j]   = is_nibble ? is_signed && (ea4[NW-1] ^ eb4[NW-1])
                                              : (j < 2) && is_signed && (ea8[BW-1] ^ eb8[BW-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prep.valid <= 1'b0;
            prep.fmt   <= tcu_fmt_pkg::FMT_I8;
        end else begin
            prep.valid <= issue.valid;
            prep.fmt   <= issue.fmt;
        end
    end

    always_ff @(posedge clk) begin
        prep.mag_a <= mag_a_d;
        prep.mag_b <= mag_b_d;
        prep.neg   <= neg_d;
        prep.c     <= issue.c;
    end

endmodule

/* rtl/tcu_prep_if.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

interface tcu_prep_if;

    // Four slots per slice with 8-bit magnitudes for byte formats
    logic                                valid;
    tcu_fmt_pkg::tcu_fmt_e               fmt;
    logic [4*`TCU_N_SLICES-1:0][7:0]     mag_a;
    logic [4*`TCU_N_SLICES-1:0][7:0]     mag_b;
    logic [4*`TCU_N_SLICES-1:0]          neg;
    logic [`TCU_DATA_W-1:0]              c;

    modport src (
        output valid, fmt, mag_a, mag_b, neg, c
    );

    modport dst (
        input valid, fmt, mag_a, mag_b, neg, c
    );

endinterface

/* rtl/tcu_issue_if.sv */
`timescale 1ns/1ps

`include "tcu_defines.svh"

interface tcu_issue_if;

    logic                                     valid;
    tcu_fmt_pkg::tcu_fmt_e                    fmt;
    logic [`TCU_N_WORDS-1:0][`TCU_DATA_W-1:0] a;
    logic [`TCU_N_WORDS-1:0][`TCU_DATA_W-1:0] b;
    logic [`TCU_DATA_W-1:0]                   c;

    modport src (
        output valid, fmt, a, b, c
    );

    modport dst (
        input valid, fmt, a, b, c
    );

endinterface

/* rtl/tcu_apb_pkg.sv */
package tcu_apb_pkg;

    // Byte addresses of the register map
    typedef enum logic [7:0] {
        REG_CTRL   = 8'h00,
        REG_A0     = 8'h04,
        REG_A1     = 8'h08,
        REG_B0     = 8'h0C,
        REG_B1     = 8'h10,
        REG_C      = 8'h14,
        REG_RESULT = 8'h18,
        REG_STATUS = 8'h1C
    } tcu_reg_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_DRAIN  = 2'd2
    } tcu_apb_state_e;

endpackage

/* rtl/tcu_fmt_pkg.sv */
package tcu_fmt_pkg;

    // Integer element formats held in CTRL[1:0]
    typedef enum logic [1:0] {
        FMT_I8 = 2'd0,
        FMT_U8 = 2'd1,
        FMT_I4 = 2'd2,
        FMT_U4 = 2'd3
    } tcu_fmt_e;

    localparam int BYTE_W   = 8;
    localparam int NIBBLE_W = 4;

    function automatic logic fmt_signed(tcu_fmt_e fmt);
        return (fmt == FMT_I8) || (fmt == FMT_I4);
    endfunction

    function automatic logic fmt_nibble(tcu_fmt_e fmt);
        return (fmt == FMT_I4) || (fmt == FMT_U4);
    endfunction

endpackage

/* include/tcu_defines.svh */
`ifndef TCU_DEFINES_SVH
`define TCU_DEFINES_SVH

// Operand vector shape
`define TCU_N_WORDS 2
`define TCU_N_SLICES (2 * `TCU_N_WORDS)

// APB bus
`define TCU_ADDR_W 8
`define TCU_DATA_W 32

// Signed partial per 16-bit slice
`define TCU_PART_W 18

`endif
